// File: dual_issue_core.f
+incdir+test
common/core_pkg.sv
common/pipe_pkg.sv
logic/register_file.sv
logic/operand_forward.sv
execute/alu.sv
execute/exe_lane.sv
logic/pipeline_core.sv
test/tb_pipeline_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipeline_core
FILELIST  ?= dual_issue_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= all tests passed

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard test/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the simulation printed the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_program.svh
// one add_pair per issued pair with lane 0 op first
task automatic load_program();
    // constants
    add_pair(imm_op(alu_add, 1, 0, 32'h0000_0013),
             imm_op(alu_lui, 2, 0, 32'h8000_0000));
    add_pair(imm_op(alu_add, 3, 0, 32'hffff_fff0),
             imm_op(alu_add, 4, 0, 32'h0000_0005));
    add_pair(imm_op(alu_lui, 5, 0, 32'h1234_5000),
             imm_op(alu_add, 6, 0, 32'h0000_0007));
    // readers at distance 3, 2 and 1
    add_pair(reg_op(alu_add, 7, 1, 3),
             reg_op(alu_sub, 8, 5, 6));
    add_pair(reg_op(alu_slt, 9, 3, 4),
             reg_op(alu_sltu, 10, 3, 4));
    add_pair(reg_op(alu_and, 11, 7, 8),
             reg_op(alu_or, 12, 7, 8));
    add_pair(reg_op(alu_nor, 13, 11, 12),
             reg_op(alu_xor, 14, 2, 5));
    add_pair(reg_op(alu_sll, 15, 5, 4),
             reg_op(alu_srl, 16, 2, 6));
    // shift amount from the low 5 bits only
    add_pair(reg_op(alu_sra, 17, 2, 6),
             imm_op(alu_sra, 18, 5, 32'h0000_0024));
    // both lanes write r20 and lane 1 must win
    add_pair(imm_op(alu_add, 20, 0, 32'h0000_0111),
             imm_op(alu_add, 20, 0, 32'h0000_0222));
    add_pair(reg_op(alu_add, 21, 20, 0),
             reg_op(alu_xor, 22, 20, 1));
    table_rows.push_back(bubble_row());
    add_pair(reg_op(alu_add, 23, 20, 20),
             pc_op(src2_imm, 24, 32'h0000_0040, 32'h0000_1000));
    // link offset and a write aimed at r0
    add_pair(pc_op(src2_link, 25, 32'h0000_0000, 32'h0000_2000),
             reg_op(alu_add, 0, 1, 3));
    add_pair(reg_op(alu_add, 26, 0, 0),
             reg_op(alu_or, 27, 0, 1));
    table_rows.push_back(stall_row());
    add_pair(reg_op(alu_sub, 28, 26, 27),
             imm_op(alu_slt, 29, 3, 32'h0000_0000));
    add_pair(reg_op(alu_sltu, 30, 3, 0),
             imm_op(alu_lui, 31, 0, 32'hdead_b000));
    // lane 1 left idle
    add_pair(reg_op(alu_add, 19, 30, 31),
             '0);
    add_pair(reg_op(alu_sra, 18, 17, 4),
             reg_op(alu_nor, 16, 0, 0));
endtask

// File: test/tb_pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_core;
    import core_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        issue_op_t i0;
        issue_op_t i1;
        logic      valid;
        logic      stall;
    } stim_row_t;

    logic      clk;
    logic      rstn;
    logic      issue_valid;
    logic      stall;
    issue_op_t issue0;
    issue_op_t issue1;
    wb_t       wb0;
    wb_t       wb1;

    stim_row_t table_rows [$];
    stim_row_t run_rows [$];
    word_t     gold_regs [nregs];
    wb_t       exp_q0 [$];
    wb_t       exp_q1 [$];
    int        errors;
    int        cycles;
    int        cycle_limit;

    pipeline_core dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .stall       (stall),
        .issue0      (issue0),
        .issue1      (issue1),
        .wb0         (wb0),
        .wb1         (wb1)
    );

    always #5 clk = ~clk;

    function automatic issue_op_t reg_op(alu_op_t op, int rd, int rj, int rk);
        issue_op_t o;
        o          = '0;
        o.valid    = 1'b1;
        o.wb_en    = 1'b1;
        o.op       = op;
        o.src1_sel = src1_rj;
        o.src2_sel = src2_rk;
        o.rd       = reg_addr_t'(rd);
        o.rj       = reg_addr_t'(rj);
        o.rk       = reg_addr_t'(rk);
        return o;
    endfunction

    function automatic issue_op_t imm_op(alu_op_t op, int rd, int rj, word_t imm);
        issue_op_t o;
        o          = reg_op(op, rd, rj, 0);
        o.src2_sel = src2_imm;
        o.imm      = imm;
        return o;
    endfunction

    // pc-relative add
    function automatic issue_op_t pc_op(src2_sel_t sel, int rd, word_t imm, word_t pc);
        issue_op_t o;
        o          = reg_op(alu_add, rd, 0, 0);
        o.src1_sel = src1_pc;
        o.src2_sel = sel;
        o.imm      = imm;
        o.pc       = pc;
        return o;
    endfunction

    function automatic stim_row_t bubble_row();
        return '{'0, '0, 1'b0, 1'b0};
    endfunction

    // a live pair that the stall has to swallow
    function automatic stim_row_t stall_row();
        return '{imm_op(alu_add, 1, 0, 32'hbad0_0001), imm_op(alu_add, 2, 0, 32'hbad0_0002),
                 1'b1, 1'b1};
    endfunction

    task automatic add_pair(issue_op_t i0, issue_op_t i1);
        table_rows.push_back('{i0, i1, 1'b1, 1'b0});
    endtask

    `include "tb_program.svh"

    function automatic word_t alu_ref(issue_op_t o, word_t rj_val, word_t rk_val);
        word_t a;
        word_t b;
        word_t r;
        a = (o.src1_sel == src1_pc) ? o.pc : rj_val;
        if (o.src2_sel == src2_rk) begin
            b = rk_val;
        end else if (o.src2_sel == src2_imm) begin
            b = o.imm;
        end else begin
            b = 32'd4;
        end
        case (o.op)
            alu_add:  r = a + b;
            alu_sub:  r = a - b;
            alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            alu_and:  r = a & b;
            alu_or:   r = a | b;
            alu_nor:  r = ~(a | b);
            alu_xor:  r = a ^ b;
            alu_sll:  r = a << b[4:0];
            alu_srl:  r = a >> b[4:0];
            // sign fill on top of a logical shift
            alu_sra:  r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            alu_lui:  r = b;
            default:  r = '0;
        endcase
        return r;
    endfunction

    // in program order, lane 0 before lane 1
    task automatic accept_pair(issue_op_t i0, issue_op_t i1);
        issue_op_t ops [2];
        wb_t       e;
        ops[0] = i0;
        ops[1] = i1;
        for (int l = 0; l < 2; l++) begin
            if (ops[l].valid) begin
                e.valid = 1'b1;
                e.wb_en = ops[l].wb_en && (ops[l].rd != '0);
                e.rd    = ops[l].rd;
                e.data  = alu_ref(ops[l], gold_regs[ops[l].rj], gold_regs[ops[l].rk]);
                if (e.wb_en) begin
                    gold_regs[e.rd] = e.data;
                end
                if (l == 0) begin
                    exp_q0.push_back(e);
                end else begin
                    exp_q1.push_back(e);
                end
            end
        end
    endtask

    task automatic compare_wb(string name, wb_t got, wb_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // a held write-back only counts at the edge that lets it go
    always @(posedge clk) begin
        if (rstn && !stall) begin
            if (wb0.valid && exp_q0.size() == 0) begin
                $display("wb0 wrote back a result that no issued pair produced");
                errors = errors + 1;
            end else if (wb0.valid) begin
                compare_wb("wb0", wb0, exp_q0.pop_front());
            end
            if (wb1.valid && exp_q1.size() == 0) begin
                $display("wb1 wrote back a result that no issued pair produced");
                errors = errors + 1;
            end else if (wb1.valid) begin
                compare_wb("wb1", wb1, exp_q1.pop_front());
            end
            if (issue_valid) begin
                accept_pair(issue0, issue1);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d write-backs never arrived",
                     cycles, exp_q0.size() + exp_q1.size());
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h79e15170));
        clk         = 1'b0;
        rstn        = 1'b0;
        issue_valid = 1'b0;
        stall       = 1'b0;
        issue0      = '0;
        issue1      = '0;
        errors      = 0;
        cycles      = 0;
        gold_regs   = '{default: '0};
        load_program();
        foreach (table_rows[i]) begin
            run_rows.push_back(table_rows[i]);
        end
        // second pass with random bubbles and stalls
        foreach (table_rows[i]) begin
            case ($urandom % 4)
                0:       run_rows.push_back(bubble_row());
                1:       run_rows.push_back(stall_row());
                default: ;
            endcase
            run_rows.push_back(table_rows[i]);
        end
        cycle_limit = 2 * run_rows.size() + 50;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (wb0.valid || wb1.valid) begin
            $display("write-back valid set right after reset");
            errors = errors + 1;
        end
        foreach (run_rows[i]) begin
            issue0      = run_rows[i].i0;
            issue1      = run_rows[i].i1;
            issue_valid = run_rows[i].valid;
            stall       = run_rows[i].stall;
            @(negedge clk);
        end
        issue_valid = 1'b0;
        stall       = 1'b0;
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(negedge clk);
        end
        // room for any stray write-back
        repeat (4) @(negedge clk);
        $display("%0d errors over %0d rows", errors, run_rows.size());
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                issue_valid,
    input  wire logic                stall,
    input  wire pipe_pkg::issue_op_t issue0,
    input  wire pipe_pkg::issue_op_t issue1,
    output pipe_pkg::wb_t            wb0,
    output pipe_pkg::wb_t            wb1
);
    import core_pkg::*;
    import pipe_pkg::*;

    issue_op_t issue_in   [2];
    issue_op_t issue_q    [2];
    exe_op_t   reg_exe0_q [2];
    exe_op_t   fwd        [2];
    wb_t       exe_res    [2];
    wb_t       wb_q       [2];
    reg_addr_t raddr      [6];
    word_t     rdata      [6];

    assign issue_in = '{issue0, issue1};

    // issue register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_q <= '{default: '0};
        end else if (!stall) begin
            for (int l = 0; l < 2; l++) begin
                if (issue_valid) begin
                    issue_q[l]       <= issue_in[l];
                    // r0 never gets written back
                    issue_q[l].wb_en <= issue_in[l].wb_en && (issue_in[l].rd != '0);
                end else begin
                    issue_q[l].valid <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            raddr[3*l]     = issue_q[l].rj;
            raddr[3*l + 1] = issue_q[l].rk;
            raddr[3*l + 2] = issue_q[l].rd;
        end
    end

    register_file u_register_file (
        .clk    (clk),
        .rstn   (rstn),
        .we0    (wb_q[0].valid && wb_q[0].wb_en && !stall),
        .we1    (wb_q[1].valid && wb_q[1].wb_en && !stall),
        .waddr0 (wb_q[0].rd),
        .waddr1 (wb_q[1].rd),
        .wdata0 (wb_q[0].data),
        .wdata1 (wb_q[1].data),
        .raddr  (raddr),
        .rdata  (rdata)
    );

    // REG-EXE0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reg_exe0_q <= '{default: '0};
        end else if (!stall) begin
            for (int l = 0; l < 2; l++) begin
                reg_exe0_q[l] <= '{
                    iss: issue_q[l],
                    rrj: rdata[3*l],
                    rrk: rdata[3*l + 1],
                    rrd: rdata[3*l + 2]
                };
            end
        end
    end

    operand_forward u_operand_forward (
        .reg_exe0  (reg_exe0_q),
        .exe0_exe1 (exe_res),
        .exe1_wb   (wb_q),
        .fwd       (fwd)
    );

    for (genvar l = 0; l < 2; l++) begin : g_lane
        exe_lane u_exe_lane (
            .clk    (clk),
            .rstn   (rstn),
            .stall  (stall),
            .op_in  (fwd[l]),
            .result (exe_res[l])
        );
    end

    // EXE1-WB
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_q <= '{default: '0};
        end else if (!stall) begin
            wb_q <= exe_res;
        end
    end

    assign wb0 = wb_q[0];
    assign wb1 = wb_q[1];

    // pairs must be independent, there is no intra-pair forwarding
    a_pair_indep: assert property (@(posedge clk) disable iff (!rstn)
        (issue_valid && !stall && issue0.valid && issue1.valid
            && issue0.wb_en && issue0.rd != '0)
        |-> !(issue1.src1_sel == src1_rj && issue1.rj == issue0.rd)
            && !(issue1.src2_sel == src2_rk && issue1.rk == issue0.rd))
        else $error("lane 1 reads r%0d written by lane 0 in the same pair", issue0.rd);

endmodule

`default_nettype wire

// File: execute/exe_lane.sv
`timescale 1ns/1ps
`default_nettype none

module exe_lane (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              stall,
    input  wire pipe_pkg::exe_op_t op_in,
    output pipe_pkg::wb_t          result
);
    import core_pkg::*;

    word_t alu_out;

    alu u_alu (
        .op       (op_in.iss.op),
        .src1_sel (op_in.iss.src1_sel),
        .src2_sel (op_in.iss.src2_sel),
        .rj_val   (op_in.rrj),
        .rk_val   (op_in.rrk),
        .imm      (op_in.iss.imm),
        .pc       (op_in.iss.pc),
        .result   (alu_out)
    );

    // EXE0-EXE1
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result <= '0;
        end else if (!stall) begin
            result.valid <= op_in.iss.valid;
            result.wb_en <= op_in.iss.wb_en;
            result.rd    <= op_in.iss.rd;
            result.data  <= alu_out;
        end
    end

    // no stale result may leave the lane right after reset
    a_idle_after_reset: assert property (@(posedge clk) $rose(rstn) |=> !result.valid)
        else $error("lane result valid right after reset");

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire pipe_pkg::alu_op_t   op,
    input  wire pipe_pkg::src1_sel_t src1_sel,
    input  wire pipe_pkg::src2_sel_t src2_sel,
    input  wire core_pkg::word_t     rj_val,
    input  wire core_pkg::word_t     rk_val,
    input  wire core_pkg::word_t     imm,
    input  wire core_pkg::word_t     pc,
    output core_pkg::word_t          result
);
    import core_pkg::*;
    import pipe_pkg::*;

    word_t src1;
    word_t src2;
    logic [4:0] shamt;

    // operand sources
    always_comb begin
        src1 = (src1_sel == src1_pc) ? pc : rj_val;
        case (src2_sel)
            src2_rk:   src2 = rk_val;
            src2_imm:  src2 = imm;
            src2_link: src2 = link_offset;
            default:   src2 = '0;
        endcase
    end

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            alu_sltu: result = {{(xlen-1){1'b0}}, src1 < src2};
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_nor:  result = ~(src1 | src2);
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = word_t'($signed(src1) >>> shamt);
            // upper immediate comes in already shifted
            alu_lui:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  wire pipe_pkg::exe_op_t reg_exe0  [2],
    input  wire pipe_pkg::wb_t     exe0_exe1 [2],
    input  wire pipe_pkg::wb_t     exe1_wb   [2],
    output pipe_pkg::exe_op_t      fwd       [2]
);
    import core_pkg::*;
    import pipe_pkg::*;

    // producers ordered oldest first, the last match wins
    wb_t prod [4];

    assign prod = '{exe1_wb[0], exe1_wb[1], exe0_exe1[0], exe0_exe1[1]};

    function automatic logic hit(wb_t p, reg_addr_t src);
        return p.valid && p.wb_en && (p.rd != '0) && (p.rd == src);
    endfunction

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            fwd[l] = reg_exe0[l];
            for (int p = 0; p < 4; p++) begin
                if (hit(prod[p], reg_exe0[l].iss.rj)) begin
                    fwd[l].rrj = prod[p].data;
                end
                if (hit(prod[p], reg_exe0[l].iss.rk)) begin
                    fwd[l].rrk = prod[p].data;
                end
                if (hit(prod[p], reg_exe0[l].iss.rd)) begin
                    fwd[l].rrd = prod[p].data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                we0,
    input  wire logic                we1,
    input  wire core_pkg::reg_addr_t waddr0,
    input  wire core_pkg::reg_addr_t waddr1,
    input  wire core_pkg::word_t     wdata0,
    input  wire core_pkg::word_t     wdata1,
    // lane 0 rj, rk, rd then lane 1 rj, rk, rd
    input  wire core_pkg::reg_addr_t raddr [6],
    output core_pkg::word_t          rdata [6]
);
    import core_pkg::*;

    word_t regs [nregs];
    logic  wen0;
    logic  wen1;

    // r0 is never a write target
    assign wen0 = we0 && (waddr0 != '0);
    assign wen1 = we1 && (waddr1 != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0) begin
                regs[waddr0] <= wdata0;
            end
            // lane 1 last, so it wins a same-register pair
            if (wen1) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // same-cycle write bypass, lane 1 first
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            if (wen1 && waddr1 == raddr[i]) begin
                rdata[i] = wdata1;
            end else if (wen0 && waddr0 == raddr[i]) begin
                rdata[i] = wdata0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

    // reads of r0 rely on this entry staying at its reset value
    a_r0_stable: assert property (@(posedge clk) disable iff (!rstn) $stable(regs[0]))
        else $error("r0 changed to %h", regs[0]);

endmodule

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_nor  = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_t;

    typedef enum logic {
        src1_rj = 1'b0,
        src1_pc = 1'b1
    } src1_sel_t;

    // 2'b11 is unused
    typedef enum logic [1:0] {
        src2_rk   = 2'd0,
        src2_imm  = 2'd1,
        src2_link = 2'd2
    } src2_sel_t;

    // decoded operation as handed to an issue lane
    typedef struct packed {
        logic                valid;
        logic                wb_en;
        alu_op_t             op;
        src1_sel_t           src1_sel;
        src2_sel_t           src2_sel;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rj;
        core_pkg::reg_addr_t rk;
        core_pkg::word_t     imm;
        core_pkg::word_t     pc;
    } issue_op_t;

    // operation plus its register values, REG-EXE0 onwards
    typedef struct packed {
        issue_op_t       iss;
        core_pkg::word_t rrj;
        core_pkg::word_t rrk;
        core_pkg::word_t rrd;
    } exe_op_t;

    // result on its way to the register file
    typedef struct packed {
        logic                valid;
        logic                wb_en;
        core_pkg::reg_addr_t rd;
        core_pkg::word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    // machine word
    localparam int xlen = 32;

    // architectural register file, r0 hardwired to zero
    localparam int nregs = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [$clog2(nregs)-1:0] reg_addr_t;

    // third src2 choice, return address offset
    localparam word_t link_offset = 32'd4;

endpackage

`default_nettype wire
